// File: common/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Datapath widths.
`define ADDR_W      16  // Byte address width.
`define WORD_W      16  // Width of one cached word.

// Cache geometry for a 2-way cache of 16-byte blocks.
`define BLOCK_WORDS 8   // Words held in one block.
`define OFFSET_BITS 4   // Byte offset within a block, address bits 3..0.
`define INDEX_BITS  6   // Set index, address bits 9..4.
`define TAG_BITS    6   // Tag, address bits 15..10.
`define SETS        64  // Number of sets.

// Backing memory.
`define MEM_WORDS   4096 // Depth in words; upper address bits alias.
`define MEM_LATENCY 4    // Cycles for each word returned on a read.

`endif

// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // States of the miss-fill controller.
  typedef enum logic [0:0] {
    FILL_IDLE = 1'b0,  // Waiting for a read miss.
    FILL_WAIT = 1'b1   // Collecting block words from memory.
  } fill_state_e;

endpackage

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Operation presented on the backing memory port.
  typedef enum logic [1:0] {
    MEM_NOP   = 2'd0,  // Port idle.
    MEM_READ  = 2'd1,  // Word read for a block fill.
    MEM_WRITE = 2'd2   // Write-through of a CPU store.
  } mem_op_e;

endpackage

`default_nettype wire

// File: cache/cache_fill_ctrl.sv
`default_nettype none

`include "cache_consts.svh"

module cache_fill_ctrl (
  input  logic                 clk,                // System clock.
  input  logic                 reset,              // Synchronous reset, active high.
  input  logic                 proceed,            // Memory grant for starting a fill.
  input  logic                 miss_detected,      // Read request that missed in the tags.
  input  logic [`ADDR_W-1:0]   miss_address,       // Address of the missing read.
  input  logic [`WORD_W-1:0]   memory_data,        // Word returned by the backing memory.
  input  logic                 memory_data_valid,  // One-cycle strobe for memory_data.
  output logic                 fill_busy,          // Holds the requester while a miss is served.
  output logic                 memory_read,        // Read request level to the memory port.
  output logic                 write_tag_array,    // Installs the new tag once all words are in.
  output logic                 write_data_array,   // Writes fill_data into the victim way.
  output logic [`TAG_BITS-1:0] fill_tag,           // Tag to install.
  output logic [`ADDR_W-1:0]   memory_address,     // Address of the next word to fetch.
  output logic [`WORD_W-1:0]   fill_data           // Word being written to the data array.
);

  cache_pkg::fill_state_e state;       // Current state.
  cache_pkg::fill_state_e next_state;  // Next state.
  logic [3:0] word_count;              // Number of words already written.
  logic       clear_count;             // Restarts the counter and loads the block base.
  logic       advance;                 // Steps the counter and the fetch address.
  logic       block_filled;            // All words of the block are in.

  assign fill_tag     = miss_address[`ADDR_W-1 -: `TAG_BITS];  // Tag bits of the miss.
  assign block_filled = (word_count == 4'(`BLOCK_WORDS));      // Eighth word has landed.

  //////////////////////////////////////////////////////////////////////
  // State, word counter and fetch address registers.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::FILL_IDLE;  // Come out of reset idle.
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      word_count <= 4'h0;
    end else if (clear_count) begin
      word_count <= 4'h0;               // New miss starts from word zero.
    end else if (advance) begin
      word_count <= word_count + 4'h1;  // One more word written.
    end
  end

  // Only the offset advances, so the index stays on the missing set through the tag write.
  always_ff @(posedge clk) begin
    if (clear_count) begin
      memory_address <= {miss_address[`ADDR_W-1:`OFFSET_BITS], `OFFSET_BITS'(0)};
    end else if (advance) begin
      memory_address <= {memory_address[`ADDR_W-1:`OFFSET_BITS],
                         memory_address[`OFFSET_BITS-1:0] + `OFFSET_BITS'(2)};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state and output decode.
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    next_state       = state;  // Stay put unless told otherwise.
    clear_count      = 1'b0;
    advance          = 1'b0;
    fill_busy        = 1'b0;
    memory_read      = 1'b0;
    write_data_array = 1'b0;
    write_tag_array  = 1'b0;
    fill_data        = '0;
    case (state)
      cache_pkg::FILL_IDLE: begin
        fill_busy   = miss_detected;  // Stall right away on a miss.
        clear_count = miss_detected;  // Capture the block base every miss cycle.
        if (miss_detected && proceed) begin
          next_state = cache_pkg::FILL_WAIT;  // Start only once memory is granted.
        end
      end
      cache_pkg::FILL_WAIT: begin
        memory_read      = ~block_filled;                      // Keep fetching until full.
        advance          = memory_data_valid & ~block_filled;  // Each strobe is one word.
        write_data_array = advance;
        fill_data        = advance ? memory_data : '0;
        fill_busy        = ~block_filled;   // Busy drops on the tag-write cycle.
        write_tag_array  = block_filled;    // Single pulse before going idle.
        if (block_filled) begin
          next_state = cache_pkg::FILL_IDLE;
        end
      end
      default: begin
        next_state = cache_pkg::FILL_IDLE;  // Recover from an illegal encoding.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: cache/tag_array.sv
`default_nettype none

`include "cache_consts.svh"

module tag_array (
  input  logic                   clk,         // System clock.
  input  logic                   reset,       // Clears every valid and LRU bit.
  input  logic [`INDEX_BITS-1:0] index,       // Set being looked up or written.
  input  logic [`TAG_BITS-1:0]   lookup_tag,  // Tag of the CPU address.
  input  logic                   read_hit,    // Accepted read hit, updates LRU.
  input  logic                   write_tag,   // Installs fill_tag in the victim way.
  input  logic [`TAG_BITS-1:0]   fill_tag,    // Tag of the block just filled.
  output logic                   hit,         // Either way matches.
  output logic                   hit_way,     // Way that matched.
  output logic                   victim_way   // Way to replace on the next fill.
);

  logic [`TAG_BITS-1:0] tags  [2][`SETS];  // Stored tags per way and set.
  logic [`SETS-1:0]     valid [2];         // Valid bit per way and set.
  logic [`SETS-1:0]     lru   [2];         // Set when the way is least recently used.
  logic                 match0;            // Way 0 holds the looked-up tag.
  logic                 match1;            // Way 1 holds the looked-up tag.

  // Both ways are compared in parallel.
  assign match0  = valid[0][index] && (tags[0][index] == lookup_tag);
  assign match1  = valid[1][index] && (tags[1][index] == lookup_tag);
  assign hit     = match0 | match1;
  assign hit_way = match1;  // Way 0 when neither matches, harmless since hit is low.

  // An empty way is filled first, otherwise the LRU way goes.
  assign victim_way = !valid[0][index] ? 1'b0 :
                      !valid[1][index] ? 1'b1 :
                      lru[1][index];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid[0] <= '0;
      valid[1] <= '0;
      lru[0]   <= '0;
      lru[1]   <= '0;
    end else if (write_tag) begin
      valid[victim_way][index] <= 1'b1;  // New block is valid.
      lru[victim_way][index]   <= 1'b0;  // And most recently used.
      lru[~victim_way][index]  <= 1'b1;  // Which leaves the other way to go next.
    end else if (read_hit) begin
      lru[hit_way][index]  <= 1'b0;
      lru[~hit_way][index] <= 1'b1;     // Other way becomes the victim.
    end
  end

  always_ff @(posedge clk) begin
    if (write_tag) begin
      tags[victim_way][index] <= fill_tag;  // Tag of the block just filled.
    end
  end

endmodule

`default_nettype wire

// File: cache/data_array.sv
`default_nettype none

`include "cache_consts.svh"

module data_array (
  input  logic                   clk,           // System clock.
  input  logic [`INDEX_BITS-1:0] index,         // Set for both ports.
  input  logic [2:0]             word_sel,      // Word within the block.
  input  logic                   read_way,      // Way driven onto read_word.
  input  logic                   write_way,     // Way written on write_enable.
  input  logic                   write_enable,  // Fill word or write hit.
  input  logic [`WORD_W-1:0]     write_word,    // Data to store.
  output logic [`WORD_W-1:0]     read_word      // Word at index, read_way, word_sel.
);

  // 64 sets by 2 ways by 8 words.
  logic [`WORD_W-1:0] words [`SETS][2][`BLOCK_WORDS];

  // Synchronous write port.
  always_ff @(posedge clk) begin
    if (write_enable) begin
      words[index][write_way][word_sel] <= write_word;
    end
  end

  // Read is combinational so a hit returns in the request cycle.
  assign read_word = words[index][read_way][word_sel];

endmodule

`default_nettype wire

// File: cache/data_cache.sv
`default_nettype none

`include "cache_consts.svh"

module data_cache (
  input  logic                 clk,             // System clock.
  input  logic                 reset,           // Synchronous reset, active high.
  input  logic                 read_enable,     // Read request level.
  input  logic                 write_enable,    // Write request level.
  input  logic                 proceed,         // Memory grant for fills.
  input  logic [`ADDR_W-1:0]   address,         // CPU byte address.
  input  logic [`WORD_W-1:0]   write_data,      // CPU store data.
  input  logic [`WORD_W-1:0]   mem_read_data,   // Word from the backing memory.
  input  logic                 mem_data_valid,  // Strobe for mem_read_data.
  output logic [`WORD_W-1:0]   read_data,       // Data of a read hit.
  output logic                 stall,           // Requester must hold its inputs.
  output mem_pkg::mem_op_e     mem_op,          // Memory operation.
  output logic [`ADDR_W-1:0]   mem_address,     // Memory byte address.
  output logic [`WORD_W-1:0]   mem_write_data   // Memory store data.
);

  logic                 hit, hit_way, victim_way;       // Tag lookup results.
  logic                 miss_detected;                  // Read without a hit.
  logic                 fill_busy, memory_read;         // Fill controller status.
  logic                 write_tag_array, write_data_array;
  logic [`TAG_BITS-1:0] fill_tag;                       // Tag to install after a fill.
  logic [`ADDR_W-1:0]   fill_address;                   // Address of the word being fetched.
  logic [`WORD_W-1:0]   fill_data;                      // Word to write during a fill.
  logic [`ADDR_W-1:0]   array_address;                  // Address steering both arrays.
  logic                 read_hit, write_hit;            // Accepted hits.

  // The fill address steers the arrays only while words are being fetched.
  assign array_address = memory_read ? fill_address : address;
  assign miss_detected = read_enable & ~hit;
  assign stall         = miss_detected | fill_busy;
  assign read_hit      = read_enable & hit & ~stall;
  assign write_hit     = write_enable & hit & ~stall;  // Write misses do not allocate.

  tag_array u_tag_array (
    .clk(clk), .reset(reset),
    .index(array_address[`OFFSET_BITS +: `INDEX_BITS]),
    .lookup_tag(address[`ADDR_W-1 -: `TAG_BITS]),
    .read_hit(read_hit), .write_tag(write_tag_array), .fill_tag(fill_tag),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
  );

  data_array u_data_array (
    .clk(clk), .index(array_address[`OFFSET_BITS +: `INDEX_BITS]),
    .word_sel(array_address[`OFFSET_BITS-1:1]),
    .read_way(hit_way), .write_way(write_data_array ? victim_way : hit_way),
    .write_enable(write_data_array | write_hit),
    .write_word(write_data_array ? fill_data : write_data), .read_word(read_data)
  );

  cache_fill_ctrl u_fill_ctrl (
    .clk(clk), .reset(reset), .proceed(proceed), .miss_detected(miss_detected),
    .miss_address(address), .memory_data(mem_read_data), .memory_data_valid(mem_data_valid),
    .fill_busy(fill_busy), .memory_read(memory_read), .write_tag_array(write_tag_array),
    .write_data_array(write_data_array), .fill_tag(fill_tag),
    .memory_address(fill_address), .fill_data(fill_data)
  );

  // Fill reads own the port; an accepted store goes straight through.
  always_comb begin
    if (memory_read) mem_op = mem_pkg::MEM_READ;
    else if (write_enable && !stall) mem_op = mem_pkg::MEM_WRITE;
    else mem_op = mem_pkg::MEM_NOP;
  end

  assign mem_address    = memory_read ? fill_address : address;
  assign mem_write_data = write_data;

endmodule

`default_nettype wire

// File: design/main_memory.sv
`default_nettype none

`include "cache_consts.svh"

module main_memory (
  input  logic                 clk,             // System clock.
  input  logic                 reset,           // Clears the latency counter.
  input  mem_pkg::mem_op_e     mem_op,          // Requested operation.
  input  logic [`ADDR_W-1:0]   mem_address,     // Byte address.
  input  logic [`WORD_W-1:0]   mem_write_data,  // Store data.
  output logic [`WORD_W-1:0]   mem_read_data,   // Word at mem_address.
  output logic                 mem_data_valid   // Read word is ready this cycle.
);

  localparam int MEM_AW = $clog2(`MEM_WORDS);       // Word address bits.
  localparam int CNT_W  = $clog2(`MEM_LATENCY);     // Latency counter width.

  logic [`WORD_W-1:0] words [`MEM_WORDS];           // Word storage.
  logic [MEM_AW-1:0]  word_address;                 // Byte address with upper bits dropped.
  logic [CNT_W-1:0]   latency_count;                // Cycles spent on the current read.

  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      words[i] = '0;  // Memory starts out cleared.
    end
  end

  assign word_address  = mem_address[MEM_AW:1];     // Upper bits alias.
  assign mem_read_data = words[word_address];

  // Last cycle of the latency window.
  assign mem_data_valid = (mem_op == mem_pkg::MEM_READ) &&
                          (latency_count == CNT_W'(`MEM_LATENCY - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      latency_count <= '0;
    end else if (mem_op != mem_pkg::MEM_READ || mem_data_valid) begin
      latency_count <= '0;                          // Restart for the next word.
    end else begin
      latency_count <= latency_count + CNT_W'(1);
    end
  end

  // Stores complete in a single cycle.
  always_ff @(posedge clk) begin
    if (mem_op == mem_pkg::MEM_WRITE) begin
      words[word_address] <= mem_write_data;
    end
  end

endmodule

`default_nettype wire

// File: design/cache_subsystem.sv
`default_nettype none

`include "cache_consts.svh"

module cache_subsystem (
  input  logic               clk,           // System clock.
  input  logic               reset,         // Synchronous reset, active high.
  input  logic               read_enable,   // Read request level.
  input  logic               write_enable,  // Write request level.
  input  logic [`ADDR_W-1:0] address,       // CPU byte address.
  input  logic [`WORD_W-1:0] write_data,    // CPU store data.
  input  logic               proceed,       // Memory grant level.
  output logic [`WORD_W-1:0] read_data,     // Read hit data.
  output logic               stall          // Hold request.
);

  mem_pkg::mem_op_e   mem_op;          // Memory operation from the cache.
  logic [`ADDR_W-1:0] mem_address;     // Memory byte address.
  logic [`WORD_W-1:0] mem_write_data;  // Store data to memory.
  logic [`WORD_W-1:0] mem_read_data;   // Fill word from memory.
  logic               mem_data_valid;  // Fill word strobe.

  data_cache u_data_cache (
    .clk(clk), .reset(reset), .read_enable(read_enable), .write_enable(write_enable),
    .proceed(proceed), .address(address), .write_data(write_data),
    .mem_read_data(mem_read_data), .mem_data_valid(mem_data_valid),
    .read_data(read_data), .stall(stall), .mem_op(mem_op),
    .mem_address(mem_address), .mem_write_data(mem_write_data)
  );

  main_memory u_main_memory (
    .clk(clk), .reset(reset), .mem_op(mem_op), .mem_address(mem_address),
    .mem_write_data(mem_write_data), .mem_read_data(mem_read_data),
    .mem_data_valid(mem_data_valid)
  );

endmodule

`default_nettype wire

// File: testbench/cache_checker.sv
`default_nettype none

module cache_checker (
  input logic                   clk,               // System clock.
  input logic                   reset,             // Synchronous reset, active high.
  input cache_pkg::fill_state_e state,             // Fill controller state.
  input logic                   fill_busy,         // Controller holds the requester.
  input logic                   memory_read,       // Fill read level.
  input logic                   write_data_array,  // Fill word strobe.
  input logic                   write_tag_array    // Tag install strobe.
);

  int failure_count = 0;  // Assertion failures seen so far, read by the testbench.

  //////////////////////////////////////////////////////////////////////
  // Fill controller rules.
  //////////////////////////////////////////////////////////////////////
  tag_write_pulse: assert property (@(posedge clk) disable iff (reset)
      write_tag_array |=> !write_tag_array)
    else begin
      $error("write_tag_array stayed high for two cycles");
      failure_count++;
    end

  data_write_busy: assert property (@(posedge clk) disable iff (reset)
      write_data_array |-> fill_busy)
    else begin
      $error("write_data_array high while fill_busy is low");
      failure_count++;
    end

  idle_no_read: assert property (@(posedge clk) disable iff (reset)
      (state == cache_pkg::FILL_IDLE) |-> !memory_read)
    else begin
      $error("memory_read high in FILL_IDLE");
      failure_count++;
    end

  // A fill only ends through the tag write.
  wait_exit_on_tag: assert property (@(posedge clk) disable iff (reset)
      (state == cache_pkg::FILL_WAIT && !write_tag_array) |=> (state == cache_pkg::FILL_WAIT))
    else begin
      $error("left FILL_WAIT without a tag write");
      failure_count++;
    end

endmodule

`default_nettype wire

// File: testbench/cache_tb.sv
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

  localparam int CLK_PERIOD      = 20;                     // Clock period in time units.
  localparam int RESET_CYCLES    = 2;                      // Rising edges with reset high.
  localparam int NUM_FILL_WRITES = 512;                    // Writes covering the first 1 KB.
  localparam int NUM_RANDOM      = 300;                    // Random mixed requests.
  localparam int NUM_DIRECTED    = 64;                     // Bound on directed requests.
  localparam int FILL_STALL      = 8 * `MEM_LATENCY + 2;   // Stall of a granted miss.
  localparam int MEM_AW          = $clog2(`MEM_WORDS);     // Word address bits.
  localparam int TOTAL_REQUESTS  = NUM_FILL_WRITES + NUM_RANDOM + NUM_DIRECTED;
  localparam int WATCHDOG_TIME   = (TOTAL_REQUESTS + RESET_CYCLES) *
                                   (8 * `MEM_LATENCY + 10) * CLK_PERIOD;

  logic               clk = 1'b0;    // System clock.
  logic               reset;         // Synchronous reset.
  logic               read_enable;   // Read request level.
  logic               write_enable;  // Write request level.
  logic [`ADDR_W-1:0] address;       // Request byte address.
  logic [`WORD_W-1:0] write_data;    // Store data.
  logic               proceed;       // Memory grant.
  logic [`WORD_W-1:0] read_data;     // DUT read data.
  logic               stall;         // DUT stall.

  logic [31:0]          lfsr = 32'heafd;             // Random generator state.
  logic [`WORD_W-1:0]   model_mem   [`MEM_WORDS];    // Expected memory contents.
  logic [`TAG_BITS-1:0] model_tag   [2][`SETS];      // Expected tags.
  logic                 model_valid [2][`SETS];      // Expected valid bits.
  logic                 model_lru   [2][`SETS];      // Expected LRU bits.
  logic [`ADDR_W-1:0]   recent      [4];             // Last four request addresses.
  int                   recent_ptr = 0;              // Next slot in recent.

  cache_subsystem dut (
    .clk(clk), .reset(reset), .read_enable(read_enable), .write_enable(write_enable),
    .address(address), .write_data(write_data), .proceed(proceed),
    .read_data(read_data), .stall(stall)
  );

  bind cache_fill_ctrl cache_checker fill_checker (
    .clk(clk), .reset(reset), .state(state), .fill_busy(fill_busy),
    .memory_read(memory_read), .write_data_array(write_data_array),
    .write_tag_array(write_tag_array)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;  // Free running clock.

  //////////////////////////////////////////////////////////////////////
  // Random numbers and the reference model.
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] value);
    return value[0] ? ((value >> 1) ^ 32'h80200003) : (value >> 1);  // Galois form.
  endfunction

  function automatic logic [15:0] next_random(input int width);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < width; i++) begin
      lfsr = lfsr_step(lfsr);        // One step per bit taken.
      bits = {bits[14:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic logic [`ADDR_W-1:0] make_address(input int tag, input int idx,
                                                      input int word);
    logic [`ADDR_W-1:0] addr;
    addr = '0;
    addr[`ADDR_W-1 -: `TAG_BITS]      = `TAG_BITS'(tag);
    addr[`OFFSET_BITS +: `INDEX_BITS] = `INDEX_BITS'(idx);
    addr[`OFFSET_BITS-1:1]            = 3'(word);
    return addr;
  endfunction

  function automatic int mem_index(input logic [`ADDR_W-1:0] addr);
    return int'(addr[MEM_AW:1]);  // Upper bits alias onto the same word.
  endfunction

  // Way holding the block, or -1 on a miss.
  function automatic int model_way(input logic [`ADDR_W-1:0] addr);
    int idx;
    idx = int'(addr[`OFFSET_BITS +: `INDEX_BITS]);
    for (int way = 0; way < 2; way++) begin
      if (model_valid[way][idx] && model_tag[way][idx] == addr[`ADDR_W-1 -: `TAG_BITS]) begin
        return way;
      end
    end
    return -1;
  endfunction

  // Installs the block in the empty way, or else in the LRU way.
  function automatic int model_fill(input logic [`ADDR_W-1:0] addr);
    int idx;
    int victim;
    idx = int'(addr[`OFFSET_BITS +: `INDEX_BITS]);
    if (!model_valid[0][idx]) victim = 0;
    else if (!model_valid[1][idx]) victim = 1;
    else victim = model_lru[1][idx] ? 1 : 0;
    model_valid[victim][idx] = 1'b1;
    model_tag[victim][idx]   = addr[`ADDR_W-1 -: `TAG_BITS];
    return victim;
  endfunction

  task automatic model_touch(input logic [`ADDR_W-1:0] addr, input int way);
    int idx;
    idx = int'(addr[`OFFSET_BITS +: `INDEX_BITS]);
    model_lru[way][idx]     = 1'b0;  // Used way is kept.
    model_lru[1 - way][idx] = 1'b1;  // The other goes next.
  endtask

  task automatic remember(input logic [`ADDR_W-1:0] addr);
    recent[recent_ptr] = addr;
    recent_ptr = (recent_ptr + 1) % 4;
  endtask

  function automatic logic [`ADDR_W-1:0] fresh_address();
    logic [15:0] bits;
    bits = next_random(MEM_AW);
    return {3'b000, bits[MEM_AW-1:0], 1'b0};  // Word aligned within 8 KB.
  endfunction

  task automatic pick_address(output logic [`ADDR_W-1:0] addr);
    logic [15:0] slot;
    if (next_random(1) != 0) begin
      slot = next_random(2);
      addr = recent[slot[1:0]];  // Reuse gives hits.
    end else begin
      addr = fresh_address();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and requests.
  //////////////////////////////////////////////////////////////////////
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, actual,
               expected);
      $display("TESTS FAILED");
      $fatal(1, "check failed: %s", what);
    end
  endtask

  // A negative grant_delay gives a random proceed each cycle.
  task automatic read_request(input logic [`ADDR_W-1:0] addr, input int grant_delay);
    int way;
    int cycles;
    int first_grant;
    way         = model_way(addr);
    cycles      = 0;
    first_grant = -1;
    forever begin
      @(negedge clk);
      read_enable  = 1'b1;
      write_enable = 1'b0;
      address      = addr;
      proceed      = (grant_delay < 0) ? (next_random(2) != 0) : (cycles >= grant_delay);
      #(CLK_PERIOD / 4);  // Outputs settled well before the rising edge.
      if (cycles == 0) check_value(stall, way < 0, "stall in first cycle of read");
      if (!stall) break;
      if (first_grant < 0 && proceed) first_grant = cycles;  // Fill starts here.
      cycles++;
    end
    if (way < 0) begin
      check_value(cycles, first_grant + FILL_STALL, "stall length of read miss");
      way = model_fill(addr);
    end
    check_value(read_data, model_mem[mem_index(addr)], "read data");
    model_touch(addr, way);
    remember(addr);
  endtask

  task automatic write_request(input logic [`ADDR_W-1:0] addr, input logic [`WORD_W-1:0] data);
    @(negedge clk);
    read_enable  = 1'b0;
    write_enable = 1'b1;
    address      = addr;
    write_data   = data;
    proceed      = (next_random(2) != 0);
    #(CLK_PERIOD / 4);
    check_value(stall, 1'b0, "stall on write");  // Hits and misses both pass straight.
    model_mem[mem_index(addr)] = data;
    remember(addr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence.
  //////////////////////////////////////////////////////////////////////
  initial begin
    logic [`ADDR_W-1:0] addr;
    logic [15:0]        bits;
    reset        = 1'b1;
    read_enable  = 1'b0;
    write_enable = 1'b0;
    address      = '0;
    write_data   = '0;
    proceed      = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) model_mem[i] = '0;
    for (int i = 0; i < `SETS; i++) begin
      for (int way = 0; way < 2; way++) begin
        model_tag[way][i]   = '0;
        model_valid[way][i] = 1'b0;
        model_lru[way][i]   = 1'b0;
      end
    end
    for (int i = 0; i < 4; i++) recent[i] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < NUM_FILL_WRITES; i++) write_request(`ADDR_W'(2 * i), next_random(16));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      pick_address(addr);
      if (next_random(1) != 0) read_request(addr, -1);
      else write_request(addr, next_random(16));
    end

    // Write hit then read back.
    for (int i = 0; i < 8; i++) begin
      addr = fresh_address();
      read_request(addr, -1);
      write_request(addr, next_random(16));
      read_request(addr, -1);
    end

    // Write miss, then a granted read miss on the aliased word.
    for (int i = 0; i < 4; i++) begin
      bits = next_random(3);
      addr = make_address(6'h3f, i * 9, int'(bits[2:0]));
      write_request(addr, next_random(16));
      read_request(addr, 0);
    end

    // Miss with the grant held back.
    read_request(make_address(6'h3e, 5, 0), 6);
    read_request(make_address(6'h3e, 6, 3), 3);

    // Three tags in one set push the first one out.
    for (int i = 0; i < 4; i++) begin
      bits = next_random(`INDEX_BITS);
      for (int t = 0; t < 3; t++) read_request(make_address(6'h30 + t, int'(bits), t), -1);
      addr = make_address(6'h30, int'(bits), 7);
      read_request(addr, -1);
    end

    @(negedge clk);
    read_enable  = 1'b0;
    write_enable = 1'b0;
    proceed      = 1'b0;
    repeat (2) @(posedge clk);
    if (dut.u_data_cache.u_fill_ctrl.fill_checker.failure_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("assertion checker flagged %0d violations",
               dut.u_data_cache.u_fill_ctrl.fill_checker.failure_count);
      $display("TESTS FAILED");
      $fatal(1, "assertion violations");
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
cache/cache_fill_ctrl.sv
cache/tag_array.sv
cache/data_array.sv
cache/data_cache.sv
design/main_memory.sv
design/cache_subsystem.sv
testbench/cache_checker.sv
testbench/cache_tb.sv
